//--- logic/core_cfg_pkg.sv
/* core sizes and widths */
package core_cfg_pkg;
    // dispatch and retire width
    localparam int width_n = 2;
    localparam int rob_depth_default = 8;

    // register files, tags below arch_regs start out mapped
    localparam int arch_regs = 8;
    localparam int phys_regs = 16;
    localparam int arch_idx_w = 3;
    localparam int phys_idx_w = 4;

    // instruction fields
    localparam int pc_w = 8;
    localparam int lat_w = 2;

    // entries per execute lane
    localparam int lane_queue_depth = 4;
endpackage

//--- logic/rob_types_pkg.sv
/* reorder buffer records */
package rob_types_pkg;
    // one slot of the reorder buffer
    typedef struct packed {
        logic valid;
        logic complete;
        logic [core_cfg_pkg::pc_w-1:0] pc;
        logic [core_cfg_pkg::arch_idx_w-1:0] dest;
        // new tag and the mapping it replaced
        logic [core_cfg_pkg::phys_idx_w-1:0] t;
        logic [core_cfg_pkg::phys_idx_w-1:0] t_old;
    } rob_entry;

    // an entry leaving the buffer
    // t_old goes back to the free list
    typedef struct packed {
        logic valid;
        logic [core_cfg_pkg::pc_w-1:0] pc;
        logic [core_cfg_pkg::arch_idx_w-1:0] dest;
        logic [core_cfg_pkg::phys_idx_w-1:0] t;
        logic [core_cfg_pkg::phys_idx_w-1:0] t_old;
    } retire_rec;
endpackage

//--- logic/rename_dispatch.sv
/* rename and dispatch */
`timescale 1ns/100ps
module rename_dispatch #(
    parameter int n = core_cfg_pkg::width_n
) (
    input  logic clock,
    input  logic reset,
    input  logic [n-1:0] in_valid,
    input  logic [n-1:0][core_cfg_pkg::pc_w-1:0] in_pc,
    input  logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] in_dest,
    input  logic [n-1:0][core_cfg_pkg::lat_w-1:0] in_lat,
    input  logic [$clog2(n+1)-1:0] open_entries,
    input  logic [n-1:0] lane_room,
    input  logic [n-1:0] free_valid,
    input  logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] free_t,
    output logic [$clog2(n+1)-1:0] accept_count,
    output logic [$clog2(n+1)-1:0] num_accept,
    output logic [n-1:0][core_cfg_pkg::pc_w-1:0] alloc_pc,
    output logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] alloc_dest,
    output logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] alloc_t,
    output logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] alloc_t_old,
    output logic [n-1:0][core_cfg_pkg::lat_w-1:0] alloc_lat
);
    localparam int cnt_w = $clog2(n+1);
    localparam int tag_w = core_cfg_pkg::phys_idx_w;
    localparam int fl_w = tag_w + 1;
    // one slot per tag, pointers wrap at phys_regs
    localparam int fl_depth = core_cfg_pkg::phys_regs;
    localparam int fl_init = core_cfg_pkg::phys_regs - core_cfg_pkg::arch_regs;

    // speculative arch to phys map
    logic [core_cfg_pkg::arch_regs-1:0][tag_w-1:0] map_table, next_map;
    // free list fifo
    logic [fl_depth-1:0][tag_w-1:0] fl_mem;
    logic [tag_w-1:0] fl_head, fl_tail;
    logic [fl_w-1:0] fl_count;
    logic [cnt_w-1:0] num_free;

    // take the longest prefix that fits every limit
    always_comb begin
        logic go;
        go = 1'b1;
        num_accept = '0;
        for (int i = 0; i < n; i++) begin
            if (go && in_valid[i] && lane_room[i] && i < open_entries && i < fl_count) begin
                num_accept = cnt_w'(i + 1);
            end else begin
                go = 1'b0;
            end
        end
    end

    assign accept_count = num_accept;

    // pop tags in slot order
    // a younger slot sees the older slot's new mapping
    always_comb begin
        next_map = map_table;
        for (int i = 0; i < n; i++) begin
            alloc_t[i] = fl_mem[fl_head + tag_w'(i)];
            alloc_t_old[i] = next_map[in_dest[i]];
            alloc_pc[i] = in_pc[i];
            alloc_dest[i] = in_dest[i];
            alloc_lat[i] = in_lat[i];
            if (i < num_accept) begin
                next_map[in_dest[i]] = alloc_t[i];
            end
        end
    end

    // freed tags arrive packed from slot 0
    always_comb begin
        num_free = '0;
        for (int k = 0; k < n; k++) begin
            num_free = num_free + cnt_w'(free_valid[k]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, free list holds the upper tags in order
            for (int r = 0; r < core_cfg_pkg::arch_regs; r++) begin
                map_table[r] <= tag_w'(r);
            end
            for (int e = 0; e < fl_depth; e++) begin
                fl_mem[e] <= tag_w'(e + core_cfg_pkg::arch_regs);
            end
            fl_head <= '0;
            fl_tail <= tag_w'(fl_init);
            fl_count <= fl_w'(fl_init);
        end else begin
            map_table <= next_map;
            // push at the tail behind last cycle's pushes
            for (int k = 0; k < n; k++) begin
                if (free_valid[k]) begin
                    fl_mem[fl_tail + tag_w'(k)] <= free_t[k];
                end
            end
            fl_head <= fl_head + tag_w'(num_accept);
            fl_tail <= fl_tail + tag_w'(num_free);
            fl_count <= fl_count - fl_w'(num_accept) + fl_w'(num_free);
        end
    end
endmodule

//--- logic/exec_lanes.sv
/* execute latency lanes */
`timescale 1ns/100ps
module exec_lanes #(
    parameter int n = core_cfg_pkg::width_n
) (
    input  logic clock,
    input  logic reset,
    input  logic [$clog2(n+1)-1:0] num_accept,
    input  logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] alloc_t,
    input  logic [n-1:0][core_cfg_pkg::lat_w-1:0] alloc_lat,
    output logic [n-1:0] lane_room,
    output logic [n-1:0] complete_valid,
    output logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] complete_t
);
    localparam int qd = core_cfg_pkg::lane_queue_depth;
    localparam int qp_w = $clog2(qd);
    localparam int qc_w = qp_w + 1;
    localparam int tag_w = core_cfg_pkg::phys_idx_w;
    localparam int lat_w = core_cfg_pkg::lat_w;

    // per lane tag and countdown storage
    logic [n-1:0][qd-1:0][tag_w-1:0] q_tag;
    logic [n-1:0][qd-1:0][lat_w-1:0] q_cd;
    logic [n-1:0][qp_w-1:0] rd_ptr, wr_ptr;
    logic [n-1:0][qc_w-1:0] q_count;
    logic [n-1:0] lane_push;

    always_comb begin
        for (int j = 0; j < n; j++) begin
            // lane j serves dispatch slot j
            lane_push[j] = j < num_accept;
            lane_room[j] = q_count[j] < qc_w'(qd);
            // head leaves once its countdown has run out
            complete_valid[j] = (q_count[j] != '0) && (q_cd[j][rd_ptr[j]] == '0);
            complete_t[j] = q_tag[j][rd_ptr[j]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            q_count <= '0;
        end else begin
            for (int j = 0; j < n; j++) begin
                rd_ptr[j] <= rd_ptr[j] + qp_w'(complete_valid[j]);
                wr_ptr[j] <= wr_ptr[j] + qp_w'(lane_push[j]);
                q_count[j] <= q_count[j] + qc_w'(lane_push[j]) - qc_w'(complete_valid[j]);
            end
        end
    end

    // all countdowns tick together, latency 0 runs as 1
    always_ff @(posedge clock) begin
        for (int j = 0; j < n; j++) begin
            for (int e = 0; e < qd; e++) begin
                if (q_cd[j][e] != '0) begin
                    q_cd[j][e] <= q_cd[j][e] - 1'b1;
                end
            end
            if (lane_push[j]) begin
                q_tag[j][wr_ptr[j]] <= alloc_t[j];
                q_cd[j][wr_ptr[j]] <= (alloc_lat[j] == '0) ? '0 : alloc_lat[j] - 1'b1;
            end
        end
    end
endmodule

//--- logic/rob.sv
/* reorder buffer */
`timescale 1ns/100ps
module rob #(
    parameter int n = core_cfg_pkg::width_n,
    parameter int depth = core_cfg_pkg::rob_depth_default
) (
    input  logic clock,
    input  logic reset,
    input  logic [$clog2(n+1)-1:0] num_accept,
    input  logic [n-1:0][core_cfg_pkg::pc_w-1:0] alloc_pc,
    input  logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] alloc_dest,
    input  logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] alloc_t,
    input  logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] alloc_t_old,
    input  logic [n-1:0] complete_valid,
    input  logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] complete_t,
    output rob_types_pkg::retire_rec [n-1:0] retire_rec,
    output logic [$clog2(n+1)-1:0] num_retired,
    output logic [$clog2(n+1)-1:0] open_entries
);
    localparam int ptr_w = $clog2(depth);
    localparam int used_w = ptr_w + 1;
    localparam int cnt_w = $clog2(n+1);

    rob_types_pkg::rob_entry [depth-1:0] entries, next_entries;
    logic [ptr_w-1:0] head, tail;
    logic [used_w-1:0] used;
    // low in reset and until the first edge after it
    logic running;

    // retire the completed run at the head
    always_comb begin
        logic go;
        logic [ptr_w-1:0] idx;
        go = 1'b1;
        num_retired = '0;
        retire_rec = '0;
        for (int i = 0; i < n; i++) begin
            idx = head + ptr_w'(i);
            if (go && entries[idx].valid && entries[idx].complete) begin
                retire_rec[i].valid = 1'b1;
                retire_rec[i].pc = entries[idx].pc;
                retire_rec[i].dest = entries[idx].dest;
                retire_rec[i].t = entries[idx].t;
                retire_rec[i].t_old = entries[idx].t_old;
                num_retired = cnt_w'(i + 1);
            end else begin
                go = 1'b0;
            end
        end
    end

    // room after this cycle's retirements, at most n
    always_comb begin
        int space;
        space = depth - int'(used) + int'(num_retired);
        if (!running) begin
            open_entries = '0;
        end else if (space > n) begin
            open_entries = cnt_w'(n);
        end else begin
            open_entries = cnt_w'(space);
        end
    end

    always_comb begin
        logic [ptr_w-1:0] idx;
        next_entries = entries;
        // tags are unique among live entries
        for (int k = 0; k < depth; k++) begin
            for (int j = 0; j < n; j++) begin
                if (complete_valid[j] && entries[k].valid && entries[k].t == complete_t[j]) begin
                    next_entries[k].complete = 1'b1;
                end
            end
        end
        // clear retired slots
        for (int i = 0; i < n; i++) begin
            if (i < num_retired) begin
                next_entries[head + ptr_w'(i)] = '0;
            end
        end
        // accepted slots go in at the tail
        for (int j = 0; j < n; j++) begin
            idx = tail + ptr_w'(j);
            if (j < num_accept) begin
                next_entries[idx].valid = 1'b1;
                next_entries[idx].complete = 1'b0;
                next_entries[idx].pc = alloc_pc[j];
                next_entries[idx].dest = alloc_dest[j];
                next_entries[idx].t = alloc_t[j];
                next_entries[idx].t_old = alloc_t_old[j];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
            head <= '0;
            tail <= '0;
            used <= '0;
            running <= 1'b0;
        end else begin
            entries <= next_entries;
            head <= head + ptr_w'(num_retired);
            tail <= tail + ptr_w'(num_accept);
            used <= used - used_w'(num_retired) + used_w'(num_accept);
            running <= 1'b1;
        end
    end
endmodule

//--- logic/retire_commit.sv
/* retire and commit */
`timescale 1ns/100ps
module retire_commit #(
    parameter int n = core_cfg_pkg::width_n
) (
    input  logic clock,
    input  logic reset,
    input  rob_types_pkg::retire_rec [n-1:0] retire_rec,
    input  logic [$clog2(n+1)-1:0] num_retired,
    output logic [n-1:0] free_valid,
    output logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] free_t,
    output logic [n-1:0] retire_valid,
    output logic [n-1:0][core_cfg_pkg::pc_w-1:0] retire_pc,
    output logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] retire_dest,
    output logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] retire_t
);
    localparam int tag_w = core_cfg_pkg::phys_idx_w;

    // committed arch to phys map
    logic [core_cfg_pkg::arch_regs-1:0][tag_w-1:0] arch_map;

    // old mappings go back to the free list
    always_comb begin
        for (int i = 0; i < n; i++) begin
            free_valid[i] = (i < num_retired) && retire_rec[i].valid;
            free_t[i] = retire_rec[i].t_old;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < core_cfg_pkg::arch_regs; r++) begin
                arch_map[r] <= tag_w'(r);
            end
            retire_valid <= '0;
        end else begin
            // slot order, so the youngest write to a dest wins
            for (int i = 0; i < n; i++) begin
                if (free_valid[i]) begin
                    arch_map[retire_rec[i].dest] <= retire_rec[i].t;
                end
            end
            retire_valid <= free_valid;
        end
    end

    // records are already packed from slot 0
    always_ff @(posedge clock) begin
        for (int i = 0; i < n; i++) begin
            retire_pc[i] <= retire_rec[i].pc;
            retire_dest[i] <= retire_rec[i].dest;
            retire_t[i] <= retire_rec[i].t;
        end
    end
endmodule

//--- logic/ooo_core_top.sv
/* out-of-order core slice */
`timescale 1ns/100ps
module ooo_core_top #(
    parameter int n = core_cfg_pkg::width_n,
    parameter int depth = core_cfg_pkg::rob_depth_default
) (
    input  logic clock,
    input  logic reset,
    input  logic [n-1:0] in_valid,
    input  logic [n-1:0][core_cfg_pkg::pc_w-1:0] in_pc,
    input  logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] in_dest,
    input  logic [n-1:0][core_cfg_pkg::lat_w-1:0] in_lat,
    output logic [$clog2(n+1)-1:0] accept_count,
    output logic [n-1:0] retire_valid,
    output logic [n-1:0][core_cfg_pkg::pc_w-1:0] retire_pc,
    output logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] retire_dest,
    output logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] retire_t
);
    localparam int cnt_w = $clog2(n+1);
    localparam int tag_w = core_cfg_pkg::phys_idx_w;

    // decode to buffer and lanes
    logic [cnt_w-1:0] num_accept, open_entries, num_retired;
    logic [n-1:0][core_cfg_pkg::pc_w-1:0] alloc_pc;
    logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] alloc_dest;
    logic [n-1:0][tag_w-1:0] alloc_t, alloc_t_old;
    logic [n-1:0][core_cfg_pkg::lat_w-1:0] alloc_lat;
    // completion and retirement
    logic [n-1:0] lane_room, complete_valid, free_valid;
    logic [n-1:0][tag_w-1:0] complete_t, free_t;
    rob_types_pkg::retire_rec [n-1:0] retire_rec;

    rename_dispatch #(.n(n)) u_dispatch (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_pc(in_pc), .in_dest(in_dest), .in_lat(in_lat),
        .open_entries(open_entries), .lane_room(lane_room),
        .free_valid(free_valid), .free_t(free_t),
        .accept_count(accept_count), .num_accept(num_accept),
        .alloc_pc(alloc_pc), .alloc_dest(alloc_dest), .alloc_t(alloc_t),
        .alloc_t_old(alloc_t_old), .alloc_lat(alloc_lat)
    );

    exec_lanes #(.n(n)) u_exec (
        .clock(clock), .reset(reset),
        .num_accept(num_accept), .alloc_t(alloc_t), .alloc_lat(alloc_lat),
        .lane_room(lane_room), .complete_valid(complete_valid), .complete_t(complete_t)
    );

    rob #(.n(n), .depth(depth)) u_rob (
        .clock(clock), .reset(reset),
        .num_accept(num_accept), .alloc_pc(alloc_pc), .alloc_dest(alloc_dest),
        .alloc_t(alloc_t), .alloc_t_old(alloc_t_old),
        .complete_valid(complete_valid), .complete_t(complete_t),
        .retire_rec(retire_rec), .num_retired(num_retired), .open_entries(open_entries)
    );

    retire_commit #(.n(n)) u_retire (
        .clock(clock), .reset(reset),
        .retire_rec(retire_rec), .num_retired(num_retired),
        .free_valid(free_valid), .free_t(free_t),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_dest(retire_dest), .retire_t(retire_t)
    );
endmodule

//--- verif/ooo_core_tb.sv
/* out-of-order core testbench */
`timescale 1ns/100ps
module ooo_core_tb;
    localparam int n = 2;
    localparam int max_prog = 64;

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic [n-1:0] in_valid = '0;
    logic [n-1:0][core_cfg_pkg::pc_w-1:0] in_pc = '0;
    logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] in_dest = '0;
    logic [n-1:0][core_cfg_pkg::lat_w-1:0] in_lat = '0;
    logic [$clog2(n+1)-1:0] accept_count;
    logic [n-1:0] retire_valid;
    logic [n-1:0][core_cfg_pkg::pc_w-1:0] retire_pc;
    logic [n-1:0][core_cfg_pkg::arch_idx_w-1:0] retire_dest;
    logic [n-1:0][core_cfg_pkg::phys_idx_w-1:0] retire_t;

    // program and expected rename results, indexed in program order
    int prog_pc [max_prog];
    int prog_dest [max_prog];
    int prog_lat [max_prog];
    int exp_t [max_prog];
    int group_start [8];
    int group_len [8];
    int prog_len, num_groups, ret_idx, errors, tests_passed, tests_failed;
    bit monitor_on;

    ooo_core_top #(.n(n), .depth(8)) uut (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_pc(in_pc), .in_dest(in_dest), .in_lat(in_lat),
        .accept_count(accept_count), .retire_valid(retire_valid),
        .retire_pc(retire_pc), .retire_dest(retire_dest), .retire_t(retire_t)
    );

    always #2 clock = ~clock;

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail %s: expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // header line, group count, then each group's length and its instructions
    task automatic read_cases(output bit ok);
        int fd;
        string hdr;
        ok = 1'b0;
        fd = $fopen("verif/ooo_core_cases.txt", "r");
        if (fd != 0) begin
            void'($fgets(hdr, fd));
            void'($fscanf(fd, "%d", num_groups));
            for (int g = 0; g < num_groups; g++) begin
                void'($fscanf(fd, "%d", group_len[g]));
                group_start[g] = prog_len;
                for (int i = 0; i < group_len[g]; i++) begin
                    void'($fscanf(fd, "%h %h %h", prog_pc[prog_len], prog_dest[prog_len],
                                  prog_lat[prog_len]));
                    prog_len++;
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    // free list model, initial tags then each t_old in program order
    task automatic build_expected();
        int fl_seq [$];
        int spec_map [core_cfg_pkg::arch_regs];
        for (int r = 0; r < core_cfg_pkg::arch_regs; r++) begin
            spec_map[r] = r;
        end
        for (int t = core_cfg_pkg::arch_regs; t < core_cfg_pkg::phys_regs; t++) begin
            fl_seq.push_back(t);
        end
        for (int i = 0; i < prog_len; i++) begin
            exp_t[i] = fl_seq.pop_front();
            fl_seq.push_back(spec_map[prog_dest[i]]);
            spec_map[prog_dest[i]] = exp_t[i];
        end
    endtask

    // retired slots compared against the program at negedge
    always @(negedge clock) begin
        if (monitor_on) begin
            if (retire_valid[1] && !retire_valid[0]) begin
                $display("retire slots are not packed from slot 0");
                errors++;
            end
            for (int i = 0; i < n; i++) begin
                if (retire_valid[i] && ret_idx >= prog_len) begin
                    $display("an instruction retired past the end of the program");
                    errors++;
                end else if (retire_valid[i]) begin
                    check_value("retire_pc", retire_pc[i], prog_pc[ret_idx]);
                    check_value("retire_dest", retire_dest[i], prog_dest[ret_idx]);
                    check_value("retire_t", retire_t[i], exp_t[ret_idx]);
                    ret_idx++;
                end
            end
        end
    end

    // slide a two slot window over one group, then wait for it to retire
    task automatic run_group(input int g, input bit idle_gaps, output bit stalled);
        int pos, stop, acc, nvalid, guard;
        pos = group_start[g];
        stop = pos + group_len[g];
        guard = 0;
        stalled = 1'b0;
        // first drive lands just after a rising edge
        @(posedge clock);
        #0.5;
        while (pos < stop && guard < 300) begin
            nvalid = 0;
            if (!(idle_gaps && ($urandom % 3) == 0)) begin
                nvalid = (stop - pos >= n) ? n : stop - pos;
            end
            for (int i = 0; i < n; i++) begin
                in_valid[i] = i < nvalid;
                in_pc[i] = (i < nvalid) ? prog_pc[pos + i] : 0;
                in_dest[i] = (i < nvalid) ? prog_dest[pos + i] : 0;
                in_lat[i] = (i < nvalid) ? prog_lat[pos + i] : 0;
            end
            @(negedge clock);
            acc = accept_count;
            if (acc < nvalid) begin
                stalled = 1'b1;
            end
            @(posedge clock);
            #0.5;
            pos += acc;
            guard++;
        end
        in_valid = '0;
        if (pos < stop) begin
            $display("timed out while dispatching group %0d", g);
            errors++;
        end
        guard = 0;
        while (ret_idx < stop && guard < 100) begin
            @(posedge clock);
            guard++;
        end
        if (ret_idx < stop) begin
            $display("timed out waiting for group %0d to retire", g);
            errors++;
        end
    endtask

    task automatic run_tests();
        int e0, e1;
        bit stalled;

        // reset held for 10 cycles with both slots offered, nothing may enter or leave
        e0 = errors;
        in_valid = '1;
        for (int c = 0; c < 10; c++) begin
            @(negedge clock);
            check_value("accept_count", accept_count, 0);
            check_value("retire_valid", retire_valid, 0);
        end
        @(posedge clock);
        #0.5;
        reset = 1'b0;
        // still closed until the first edge out of reset
        @(negedge clock);
        check_value("accept_count", accept_count, 0);
        @(posedge clock);
        #0.5;
        in_valid = '0;
        for (int c = 0; c < 4; c++) begin
            @(negedge clock);
            check_value("retire_valid", retire_valid, 0);
        end
        end_test("reset", e0);

        monitor_on = 1'b1;
        e0 = errors;
        run_group(0, 1'b0, stalled);
        end_test("in-order retirement and renaming", e0);

        e1 = errors;
        run_group(1, 1'b0, stalled);
        if (!stalled) begin
            $display("accept_count never dropped below the valid slot count");
            errors++;
        end
        end_test("back-pressure", e1);

        if (ret_idx <= core_cfg_pkg::phys_regs - core_cfg_pkg::arch_regs) begin
            $display("stream too short to recycle tags");
            errors++;
        end
        end_test("tag recycling", e0);

        e0 = errors;
        run_group(2, 1'b1, stalled);
        check_value("retired_total", ret_idx, prog_len);
        end_test("idle gaps", e0);
    endtask

    initial begin
        bit cases_ok;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        ret_idx = 0;
        prog_len = 0;
        monitor_on = 1'b0;
        void'($urandom(72766));
        read_cases(cases_ok);
        if (!cases_ok) begin
            $display("cannot open the case file");
            $display("Test failed");
        end else begin
            build_expected();
            run_tests();
            $display("tests passed %0d failed %0d", tests_passed, tests_failed);
            if (tests_failed == 0 && errors == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end
endmodule

//--- verif/ooo_core_cases.txt
// pc dest latency in hex; line 2 is the group count, each group opens with its length
3
6
10 1 3
11 1 1
12 2 2
13 3 1
14 2 0
15 5 3
12
20 0 3
21 1 3
22 2 3
23 3 3
24 4 3
25 5 3
26 6 3
27 7 3
28 0 3
29 0 3
2a 1 3
2b 2 3
4
30 6 1
31 6 2
32 4 3
33 7 1

//--- ooo_core.f
logic/core_cfg_pkg.sv
logic/rob_types_pkg.sv
logic/rename_dispatch.sv
logic/exec_lanes.sv
logic/rob.sv
logic/retire_commit.sv
logic/ooo_core_top.sv
verif/ooo_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= ooo_core_tb
FILELIST ?= ooo_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
CASES ?= verif/ooo_core_cases.txt

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN) $(CASES)
	$(BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
